//--- files.f
src/bus_pkg.sv
src/integrity_pkg.sv
src/achk_encoder.sv
src/rchk_checker.sv
src/integrity_alert_regs.sv
src/obi_integrity_top.sv
sim/tb_clk_gen.sv
sim/obi_integrity_chk.sv
sim/obi_integrity_tb.sv

//--- sim/obi_integrity_chk.sv
//////////////////////////////
// Concurrent assertions bound onto the integrity top level.
// Covers the fetch request parity and the alert registers.
//////////////////////////////

module obi_integrity_chk (
  input logic                      clk,
  input logic                      rst_ni,
  input logic                      instr_req_i,
  input logic                      instr_reqpar_i,
  input logic                      clr_i,
  input logic                      alert_i,
  input integrity_pkg::err_class_e first_cause_i
);

  // Number of assertion failures, the testbench polls it
  int unsigned fail_count = 0;

  // Request parity is the inverted strobe in every cycle
  reqpar_inverse: assert property (
    @(posedge clk) disable iff (!rst_ni) instr_reqpar_i == !instr_req_i
  ) else begin
    $error("instr_reqpar_o is not the inverse of instr_req_i");
    fail_count++;
  end

  // Only a clear strobe at the previous edge may drop the alert
  alert_sticky: assert property (
    @(posedge clk) disable iff (!rst_ni) $fell(alert_i) |-> $past(clr_i)
  ) else begin
    $error("alert_o fell without a clear strobe");
    fail_count++;
  end

  // The first cause holds for as long as the alert stays up
  cause_stable: assert property (
    @(posedge clk) disable iff (!rst_ni) (alert_i && $past(alert_i)) |-> $stable(first_cause_i)
  ) else begin
    $error("first_cause_o changed while alert_o stayed high");
    fail_count++;
  end

endmodule

//--- sim/obi_integrity_tb.sv
//////////////////////////////
// Testbench for the bus integrity unit. Random requests and
// responses from a fixed seed, about one response in eight
// corrupted, every output compared with a cycle model.
//////////////////////////////

module obi_integrity_tb;

  localparam int PERIOD   = 4;
  localparam int N_RANDOM = 1500;
  localparam int N_DIRECT = 40;
  localparam int TIMEOUT  = (N_RANDOM + N_DIRECT + 8) * PERIOD + 100;

  logic                      clk;
  logic                      rst_ni;
  logic                      instr_req_i;
  bus_pkg::addr_t            instr_addr_i;
  bus_pkg::prot_t            instr_prot_i;
  bus_pkg::memtype_t         instr_memtype_i;
  logic                      instr_dbg_i;
  logic                      instr_gnt_i;
  logic                      instr_gntpar_i;
  logic                      instr_rvalid_i;
  logic                      instr_rvalidpar_i;
  bus_pkg::data_t            instr_rdata_i;
  logic                      instr_err_i;
  integrity_pkg::rchk_t      instr_rchk_i;
  logic                      instr_reqpar_o;
  integrity_pkg::achk_t      instr_achk_o;
  logic                      data_req_i;
  logic                      data_we_i;
  bus_pkg::be_t              data_be_i;
  bus_pkg::addr_t            data_addr_i;
  bus_pkg::data_t            data_wdata_i;
  bus_pkg::prot_t            data_prot_i;
  bus_pkg::memtype_t         data_memtype_i;
  logic                      data_dbg_i;
  logic                      data_gnt_i;
  logic                      data_gntpar_i;
  logic                      data_rvalid_i;
  logic                      data_rvalidpar_i;
  bus_pkg::data_t            data_rdata_i;
  logic                      data_err_i;
  integrity_pkg::rchk_t      data_rchk_i;
  logic                      data_reqpar_o;
  integrity_pkg::achk_t      data_achk_o;
  logic                      cfg_we_i;
  integrity_pkg::err_vec_t   cfg_mask_i;
  logic                      clr_i;
  integrity_pkg::err_vec_t   mask_o;
  integrity_pkg::err_vec_t   status_o;
  integrity_pkg::err_class_e first_cause_o;
  logic                      alert_o;

  integer seed;

  // Cycle model of the checker flags and the register block
  integrity_pkg::err_vec_t m_flags;
  integrity_pkg::err_vec_t m_mask;
  integrity_pkg::err_vec_t m_status;
  logic [1:0]              m_cause;
  logic                    m_alert;

  tb_clk_gen #(.PERIOD(PERIOD)) i_clk_gen (.clk_o(clk));

  obi_integrity_top i_dut (.*);

  bind obi_integrity_top obi_integrity_chk i_chk (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_reqpar_i (instr_reqpar_o),
    .clr_i          (clr_i),
    .alert_i        (alert_o),
    .first_cause_i  (first_cause_o)
  );

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  // Check bit that makes the group plus itself hold an odd number of ones
  function automatic logic odd_parity(input logic [31:0] bits, input int width);
    int ones;
    ones = 0;
    for (int i = 0; i < width; i++) begin
      ones += bits[i];
    end
    return (ones % 2) == 0;
  endfunction

  function automatic integrity_pkg::achk_t model_achk(
      input logic [31:0] addr, input logic [2:0] prot, input logic [1:0] memtype,
      input logic dbg, input logic we, input logic [3:0] be, input logic [31:0] wdata);
    integrity_pkg::achk_t sum;
    for (int b = 0; b < 4; b++) begin
      sum[b]     = odd_parity(addr >> (8 * b), 8);
      sum[8 + b] = odd_parity(wdata >> (8 * b), 8);
    end
    sum[4] = odd_parity({prot, memtype}, 5);
    sum[5] = odd_parity({be, we}, 5);
    sum[6] = odd_parity(dbg, 1);
    sum[7] = odd_parity(6'b0, 6);
    return sum;
  endfunction

  function automatic integrity_pkg::rchk_t model_rchk(input logic [31:0] rdata, input logic err);
    integrity_pkg::rchk_t sum;
    for (int b = 0; b < 4; b++) begin
      sum[b] = odd_parity(rdata >> (8 * b), 8);
    end
    sum[4] = odd_parity(err, 1);
    return sum;
  endfunction

  // State update at a rising edge, from the inputs held before it
  task automatic model_edge();
    integrity_pkg::err_vec_t en;
    int lowest;
    en     = m_flags & m_mask;
    lowest = -1;
    for (int c = 0; c < 4; c++) begin
      if (en[c] && lowest < 0) lowest = c;
    end
    if (clr_i) begin
      m_status = '0;
      m_cause  = 2'd0;
      m_alert  = 1'b0;
    end else begin
      m_status = m_status | en;
      if (!m_alert && lowest >= 0) begin
        m_cause = lowest;
        m_alert = 1'b1;
      end
    end
    if (cfg_we_i) m_mask = cfg_mask_i;
    m_flags[0] = (instr_gntpar_i == instr_gnt_i) || (instr_rvalidpar_i == instr_rvalid_i);
    m_flags[1] = instr_rvalid_i && (instr_rchk_i !== model_rchk(instr_rdata_i, instr_err_i));
    m_flags[2] = (data_gntpar_i == data_gnt_i) || (data_rvalidpar_i == data_rvalid_i);
    m_flags[3] = data_rvalid_i && (data_rchk_i !== model_rchk(data_rdata_i, data_err_i));
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Outputs are compared well after the drive point and before the next edge
  task automatic settle_and_check();
    #1;
    check_value("instr_reqpar_o", instr_reqpar_o, !instr_req_i);
    check_value("instr_achk_o", instr_achk_o, model_achk(instr_addr_i, instr_prot_i,
                instr_memtype_i, instr_dbg_i, 1'b0, 4'hf, 32'h0));
    check_value("data_reqpar_o", data_reqpar_o, !data_req_i);
    check_value("data_achk_o", data_achk_o, model_achk(data_addr_i, data_prot_i,
                data_memtype_i, data_dbg_i, data_we_i, data_be_i, data_wdata_i));
    check_value("mask_o", mask_o, m_mask);
    check_value("status_o", status_o, m_status);
    check_value("first_cause_o", first_cause_o, m_cause);
    check_value("alert_o", alert_o, m_alert);
    assert (i_dut.i_chk.fail_count == 0) else begin
      $display("A bound assertion on the DUT failed before time %0t", $time);
      stop_on_failure();
    end
  endtask

  task automatic expect_regs(input logic [3:0] mask, input logic [3:0] status,
                             input logic [1:0] cause, input logic alert);
    check_value("mask_o", mask_o, mask);
    check_value("status_o", status_o, status);
    check_value("first_cause_o", first_cause_o, cause);
    check_value("alert_o", alert_o, alert);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic make_response(input logic fault_ok, output logic gnt, output logic gntpar,
                               output logic rvalid, output logic rvalidpar,
                               output bus_pkg::data_t rdata, output logic err,
                               output integrity_pkg::rchk_t rchk);
    integer pick;
    gnt       = $random(seed);
    rvalid    = $random(seed);
    rdata     = $random(seed);
    err       = $random(seed);
    gntpar    = ~gnt;
    rvalidpar = ~rvalid;
    rchk      = model_rchk(rdata, err);
    pick      = $random(seed);
    // Roughly one response in eight gets a single flipped integrity bit
    if (fault_ok && pick[2:0] == 3'd0) begin
      case (pick[4:3])
        2'd0:    gntpar = ~gntpar;
        2'd1:    rvalidpar = ~rvalidpar;
        default: rchk = rchk ^ (5'b1 << (pick[7:5] % 5));
      endcase
    end
  endtask

  task automatic drive_cycle(input logic random_faults);
    integer ctrl;
    instr_req_i     = $random(seed);
    instr_addr_i    = $random(seed);
    instr_prot_i    = $random(seed);
    instr_memtype_i = $random(seed);
    instr_dbg_i     = $random(seed);
    data_req_i      = $random(seed);
    data_we_i       = $random(seed);
    data_be_i       = $random(seed);
    data_addr_i     = $random(seed);
    data_wdata_i    = $random(seed);
    data_prot_i     = $random(seed);
    data_memtype_i  = $random(seed);
    data_dbg_i      = $random(seed);
    make_response(random_faults, instr_gnt_i, instr_gntpar_i, instr_rvalid_i,
                  instr_rvalidpar_i, instr_rdata_i, instr_err_i, instr_rchk_i);
    make_response(random_faults, data_gnt_i, data_gntpar_i, data_rvalid_i,
                  data_rvalidpar_i, data_rdata_i, data_err_i, data_rchk_i);
    ctrl       = $random(seed);
    cfg_mask_i = ctrl[7:4];
    cfg_we_i   = random_faults && (ctrl[12:8] == 5'd0);
    clr_i      = random_faults && (ctrl[16:13] == 4'd0);
  endtask

  // Clean cycle with the chosen error classes forced
  task automatic inject(input integrity_pkg::err_vec_t faults);
    drive_cycle(1'b0);
    if (faults[0]) instr_gntpar_i = instr_gnt_i;
    if (faults[1]) begin
      instr_rvalid_i    = 1'b1;
      instr_rvalidpar_i = 1'b0;
      instr_rchk_i      = ~model_rchk(instr_rdata_i, instr_err_i);
    end
    if (faults[2]) data_gntpar_i = data_gnt_i;
    if (faults[3]) begin
      data_rvalid_i    = 1'b1;
      data_rvalidpar_i = 1'b0;
      data_rchk_i      = model_rchk(data_rdata_i, data_err_i) ^ 5'b10000;
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    model_edge();
    #1;
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n) begin
      next_edge();
      drive_cycle(1'b0);
      settle_and_check();
    end
  endtask

  task automatic clear_and_mask(input integrity_pkg::err_vec_t mask);
    next_edge();
    drive_cycle(1'b0);
    clr_i      = 1'b1;
    cfg_we_i   = 1'b1;
    cfg_mask_i = mask;
    settle_and_check();
    quiet_cycles(2);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed     = 32'hc982_7e8a;
    rst_ni   = 1'b0;
    drive_cycle(1'b0);
    m_flags  = '0;
    m_mask   = '1;
    m_status = '0;
    m_cause  = 2'd0;
    m_alert  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    settle_and_check();

    for (int n = 0; n < N_RANDOM; n++) begin
      next_edge();
      drive_cycle(1'b1);
      settle_and_check();
    end

    // One fetch checksum error reaches status and alert two edges later
    clear_and_mask(4'hf);
    expect_regs(4'hf, 4'h0, 2'd0, 1'b0);
    next_edge();
    inject(4'b0010);
    settle_and_check();
    quiet_cycles(1);
    expect_regs(4'hf, 4'h0, 2'd0, 1'b0);
    quiet_cycles(1);
    expect_regs(4'hf, 4'b0010, 2'd1, 1'b1);

    // A masked class leaves status and alert alone
    clear_and_mask(4'b1011);
    next_edge();
    inject(4'b0100);
    settle_and_check();
    quiet_cycles(2);
    expect_regs(4'b1011, 4'h0, 2'd0, 1'b0);

    // Several classes at once, then a later error of higher priority
    clear_and_mask(4'hf);
    next_edge();
    inject(4'b1110);
    settle_and_check();
    quiet_cycles(2);
    expect_regs(4'hf, 4'b1110, 2'd1, 1'b1);
    next_edge();
    inject(4'b0001);
    settle_and_check();
    quiet_cycles(2);
    expect_regs(4'hf, 4'b1111, 2'd1, 1'b1);

    // Clear meets a new flag at the same edge
    next_edge();
    inject(4'b1000);
    settle_and_check();
    next_edge();
    drive_cycle(1'b0);
    clr_i = 1'b1;
    settle_and_check();
    quiet_cycles(2);
    expect_regs(4'hf, 4'h0, 2'd0, 1'b0);

    if (i_dut.i_chk.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "A bound assertion failed near the end of the run");
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Watchdog expired after %0d time units, the test did not finish", TIMEOUT);
    $display("Checks failed");
    $fatal(1, "Timeout");
  end

endmodule

//--- sim/tb_clk_gen.sv
//////////////////////////////
// Free running testbench clock, starts low.
//////////////////////////////

module tb_clk_gen #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- src/achk_encoder.sv
//////////////////////////////
// Request parity and address-phase checksum for one port.
// Purely combinational. Set HAS_WDATA to 0 for the fetch port,
// which then ignores we_i, be_i and wdata_i.
//////////////////////////////

module achk_encoder #(
  parameter bit HAS_WDATA = 1'b1
) (
  input  logic                  req_i,
  input  bus_pkg::addr_t        addr_i,
  input  bus_pkg::prot_t        prot_i,
  input  bus_pkg::memtype_t     memtype_i,
  input  logic                  dbg_i,
  input  logic                  we_i,
  input  bus_pkg::be_t          be_i,
  input  bus_pkg::data_t        wdata_i,
  output logic                  reqpar_o,
  output integrity_pkg::achk_t  achk_o
);

  // Field values that actually enter the checksum
  logic           we_s;
  bus_pkg::be_t   be_s;
  bus_pkg::data_t wdata_s;

  // Reserved group is always transmitted as zero
  logic [integrity_pkg::RSVD_W-1:0] rsvd;

  //////////////////////////////
  // Port specific fields
  //////////////////////////////

  if (HAS_WDATA) begin : g_data_port
    assign we_s    = we_i;
    assign be_s    = be_i;
    assign wdata_s = wdata_i;
  end else begin : g_fetch_port
    // A fetch is a full-word read with no write data
    assign we_s    = 1'b0;
    assign be_s    = '1;
    assign wdata_s = '0;
  end

  assign rsvd = '0;

  //////////////////////////////
  // Parity and checksum
  //////////////////////////////

  // Request parity is simply the inverted strobe
  assign reqpar_o = ~req_i;

  // Each checksum bit is the odd parity of one field group

  // Address bytes, least significant first
  assign achk_o[0] = ~^addr_i[7:0];
  assign achk_o[1] = ~^addr_i[15:8];
  assign achk_o[2] = ~^addr_i[23:16];
  assign achk_o[3] = ~^addr_i[31:24];

  // Attribute groups
  assign achk_o[4] = ~^{prot_i, memtype_i};
  assign achk_o[5] = ~^{be_s, we_s};
  assign achk_o[6] = ~^dbg_i;
  assign achk_o[7] = ~^rsvd;

  // Write data bytes, least significant first
  assign achk_o[8]  = ~^wdata_s[7:0];
  assign achk_o[9]  = ~^wdata_s[15:8];
  assign achk_o[10] = ~^wdata_s[23:16];
  assign achk_o[11] = ~^wdata_s[31:24];

endmodule

//--- src/bus_pkg.sv
//////////////////////////////
// Field widths and vector types of the two memory ports.
// The encoders, checkers and top level refer to these by
// scoped name.
//////////////////////////////

package bus_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Address and data path of both ports
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // One byte enable per data byte
  localparam int unsigned BE_W = DATA_W / 8;

  // Protection covers privilege, data/instruction and the reserved bit
  localparam int unsigned PROT_W = 3;

  // Memory type is bufferable and cacheable
  localparam int unsigned MEMTYPE_W = 2;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // Byte address of a request
  typedef logic [ADDR_W-1:0] addr_t;

  // Write data on the request or read data on the response
  typedef logic [DATA_W-1:0] data_t;

  // Byte enables of a data request
  typedef logic [BE_W-1:0] be_t;

  // Protection attributes
  typedef logic [PROT_W-1:0] prot_t;

  // Memory type attributes
  typedef logic [MEMTYPE_W-1:0] memtype_t;

endpackage

//--- src/integrity_alert_regs.sv
//////////////////////////////
// Configuration and status of the bus integrity unit.
// Holds the enable mask, sticky status and the first error
// cause, and raises the major alert on the first enabled error.
//////////////////////////////

module integrity_alert_regs (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  integrity_pkg::err_vec_t     err_i,
  input  logic                        cfg_we_i,
  input  integrity_pkg::err_vec_t     cfg_mask_i,
  input  logic                        clr_i,
  output integrity_pkg::err_vec_t     mask_o,
  output integrity_pkg::err_vec_t     status_o,
  output integrity_pkg::err_class_e   first_cause_o,
  output logic                        alert_o
);

  integrity_pkg::err_vec_t     mask_q;
  integrity_pkg::err_vec_t     status_q;
  integrity_pkg::err_vec_t     status_d;
  integrity_pkg::err_vec_t     err_en;
  integrity_pkg::err_class_e   cause_q;
  integrity_pkg::err_class_e   cause_d;
  integrity_pkg::err_class_e   cause_sel;
  integrity_pkg::alert_state_e state_q;
  integrity_pkg::alert_state_e state_d;

  //////////////////////////////
  // Mask
  //////////////////////////////

  // A new mask applies to flags sampled after the write edge
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '1;
    end else if (cfg_we_i) begin
      mask_q <= cfg_mask_i;
    end
  end

  assign err_en = err_i & mask_q;

  //////////////////////////////
  // Status and first cause
  //////////////////////////////

  // Fixed priority, the lowest class code wins
  always_comb begin
    cause_sel = integrity_pkg::ERR_INSTR_HS;
    for (int i = integrity_pkg::N_ERR - 1; i >= 0; i--) begin
      if (err_en[i]) begin
        cause_sel = integrity_pkg::err_class_e'(i);
      end
    end
  end

  // Clear takes precedence over anything arriving at the same edge
  always_comb begin
    status_d = status_q | err_en;
    cause_d  = cause_q;
    state_d  = state_q;
    if (clr_i) begin
      status_d = '0;
      cause_d  = integrity_pkg::ERR_INSTR_HS;
      state_d  = integrity_pkg::ALERT_IDLE;
    end else begin
      case (state_q)
        integrity_pkg::ALERT_IDLE: begin
          if (|err_en) begin
            cause_d = cause_sel;
            state_d = integrity_pkg::ALERT_CAPTURED;
          end
        end
        // Later errors only add to the status
        integrity_pkg::ALERT_CAPTURED: begin
          state_d = integrity_pkg::ALERT_CAPTURED;
        end
        default: begin
          state_d = integrity_pkg::ALERT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
      cause_q  <= integrity_pkg::ERR_INSTR_HS;
      state_q  <= integrity_pkg::ALERT_IDLE;
    end else begin
      status_q <= status_d;
      cause_q  <= cause_d;
      state_q  <= state_d;
    end
  end

  assign mask_o        = mask_q;
  assign status_o      = status_q;
  assign first_cause_o = cause_q;

  // Alert comes straight from the state register
  assign alert_o = (state_q == integrity_pkg::ALERT_CAPTURED);

endmodule

//--- src/integrity_pkg.sv
//////////////////////////////
// Checksum widths, error classes and alert states of the
// bus integrity unit.
//////////////////////////////

package integrity_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Address-phase checksum, one bit per field group
  localparam int unsigned ACHK_W = 12;

  // Response checksum, four data bytes and the error bit
  localparam int unsigned RCHK_W = 5;

  // Reserved field group covered by address-phase checksum bit 7
  localparam int unsigned RSVD_W = 6;

  // Number of error classes reported to the register block
  localparam int unsigned N_ERR = 4;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [ACHK_W-1:0] achk_t;
  typedef logic [RCHK_W-1:0] rchk_t;

  // One bit per error class, indexed by err_class_e
  typedef logic [N_ERR-1:0] err_vec_t;

  // Error classes, lowest code has the highest priority
  typedef enum logic [1:0] {
    ERR_INSTR_HS   = 2'd0,
    ERR_INSTR_RCHK = 2'd1,
    ERR_DATA_HS    = 2'd2,
    ERR_DATA_RCHK  = 2'd3
  } err_class_e;

  // Alert state machine
  typedef enum logic {
    ALERT_IDLE     = 1'b0,
    ALERT_CAPTURED = 1'b1
  } alert_state_e;

endpackage

//--- src/obi_integrity_top.sv
//////////////////////////////
// Bus integrity unit for the fetch and data ports.
// Encodes request parity and checksum, checks the responses
// and reports errors through the alert register block.
//////////////////////////////

module obi_integrity_top (
  input  logic                       clk,
  input  logic                       rst_ni,

  // Instruction fetch port
  input  logic                       instr_req_i,
  input  bus_pkg::addr_t             instr_addr_i,
  input  bus_pkg::prot_t             instr_prot_i,
  input  bus_pkg::memtype_t          instr_memtype_i,
  input  logic                       instr_dbg_i,
  input  logic                       instr_gnt_i,
  input  logic                       instr_gntpar_i,
  input  logic                       instr_rvalid_i,
  input  logic                       instr_rvalidpar_i,
  input  bus_pkg::data_t             instr_rdata_i,
  input  logic                       instr_err_i,
  input  integrity_pkg::rchk_t       instr_rchk_i,
  output logic                       instr_reqpar_o,
  output integrity_pkg::achk_t       instr_achk_o,

  // Data port
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  bus_pkg::be_t               data_be_i,
  input  bus_pkg::addr_t             data_addr_i,
  input  bus_pkg::data_t             data_wdata_i,
  input  bus_pkg::prot_t             data_prot_i,
  input  bus_pkg::memtype_t          data_memtype_i,
  input  logic                       data_dbg_i,
  input  logic                       data_gnt_i,
  input  logic                       data_gntpar_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_rvalidpar_i,
  input  bus_pkg::data_t             data_rdata_i,
  input  logic                       data_err_i,
  input  integrity_pkg::rchk_t       data_rchk_i,
  output logic                       data_reqpar_o,
  output integrity_pkg::achk_t       data_achk_o,

  // Configuration and status
  input  logic                       cfg_we_i,
  input  integrity_pkg::err_vec_t    cfg_mask_i,
  input  logic                       clr_i,
  output integrity_pkg::err_vec_t    mask_o,
  output integrity_pkg::err_vec_t    status_o,
  output integrity_pkg::err_class_e  first_cause_o,
  output logic                       alert_o
);

  logic                    instr_hs_err;
  logic                    instr_rchk_err;
  logic                    data_hs_err;
  logic                    data_rchk_err;
  integrity_pkg::err_vec_t err_vec;

  //////////////////////////////
  // Request side
  //////////////////////////////

  // The fetch encoder substitutes its own write fields
  achk_encoder #(.HAS_WDATA(1'b0)) i_instr_achk (
    .req_i     (instr_req_i),
    .addr_i    (instr_addr_i),
    .prot_i    (instr_prot_i),
    .memtype_i (instr_memtype_i),
    .dbg_i     (instr_dbg_i),
    .we_i      (1'b0),
    .be_i      ('1),
    .wdata_i   ('0),
    .reqpar_o  (instr_reqpar_o),
    .achk_o    (instr_achk_o)
  );

  achk_encoder #(.HAS_WDATA(1'b1)) i_data_achk (
    .req_i     (data_req_i),
    .addr_i    (data_addr_i),
    .prot_i    (data_prot_i),
    .memtype_i (data_memtype_i),
    .dbg_i     (data_dbg_i),
    .we_i      (data_we_i),
    .be_i      (data_be_i),
    .wdata_i   (data_wdata_i),
    .reqpar_o  (data_reqpar_o),
    .achk_o    (data_achk_o)
  );

  //////////////////////////////
  // Response side
  //////////////////////////////

  rchk_checker i_instr_rchk (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .gnt_i       (instr_gnt_i),
    .gntpar_i    (instr_gntpar_i),
    .rvalid_i    (instr_rvalid_i),
    .rvalidpar_i (instr_rvalidpar_i),
    .rdata_i     (instr_rdata_i),
    .err_i       (instr_err_i),
    .rchk_i      (instr_rchk_i),
    .hs_err_o    (instr_hs_err),
    .rchk_err_o  (instr_rchk_err)
  );

  rchk_checker i_data_rchk (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .gnt_i       (data_gnt_i),
    .gntpar_i    (data_gntpar_i),
    .rvalid_i    (data_rvalid_i),
    .rvalidpar_i (data_rvalidpar_i),
    .rdata_i     (data_rdata_i),
    .err_i       (data_err_i),
    .rchk_i      (data_rchk_i),
    .hs_err_o    (data_hs_err),
    .rchk_err_o  (data_rchk_err)
  );

  // Flags land on the bit of their class code
  assign err_vec[integrity_pkg::ERR_INSTR_HS]   = instr_hs_err;
  assign err_vec[integrity_pkg::ERR_INSTR_RCHK] = instr_rchk_err;
  assign err_vec[integrity_pkg::ERR_DATA_HS]    = data_hs_err;
  assign err_vec[integrity_pkg::ERR_DATA_RCHK]  = data_rchk_err;

  integrity_alert_regs i_alert_regs (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .err_i         (err_vec),
    .cfg_we_i      (cfg_we_i),
    .cfg_mask_i    (cfg_mask_i),
    .clr_i         (clr_i),
    .mask_o        (mask_o),
    .status_o      (status_o),
    .first_cause_o (first_cause_o),
    .alert_o       (alert_o)
  );

endmodule

//--- src/rchk_checker.sv
//////////////////////////////
// Handshake parity and response checksum checker for one port.
// Both error flags are registered and stay high for one cycle
// per faulty sample.
//////////////////////////////

module rchk_checker (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  gnt_i,
  input  logic                  gntpar_i,
  input  logic                  rvalid_i,
  input  logic                  rvalidpar_i,
  input  bus_pkg::data_t        rdata_i,
  input  logic                  err_i,
  input  integrity_pkg::rchk_t  rchk_i,
  output logic                  hs_err_o,
  output logic                  rchk_err_o
);

  // Expected values derived from the sampled bus signals
  logic                 gntpar_exp;
  logic                 rvalidpar_exp;
  integrity_pkg::rchk_t rchk_exp;

  // Unregistered error conditions
  logic hs_err_d;
  logic rchk_err_d;

  //////////////////////////////
  // Expected parity and checksum
  //////////////////////////////

  // Each strobe travels with its inverse
  assign gntpar_exp    = ~gnt_i;
  assign rvalidpar_exp = ~rvalid_i;

  // Read data bytes in the low bits, error bit on top
  assign rchk_exp[0] = ~^rdata_i[7:0];
  assign rchk_exp[1] = ~^rdata_i[15:8];
  assign rchk_exp[2] = ~^rdata_i[23:16];
  assign rchk_exp[3] = ~^rdata_i[31:24];
  assign rchk_exp[4] = ~^err_i;

  //////////////////////////////
  // Compare
  //////////////////////////////

  // Handshake parity is checked in every cycle, the strobes are always driven
  assign hs_err_d = (gntpar_i != gntpar_exp) || (rvalidpar_i != rvalidpar_exp);

  // The checksum only means something while a response is valid
  assign rchk_err_d = rvalid_i && (rchk_i != rchk_exp);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      hs_err_o   <= 1'b0;
      rchk_err_o <= 1'b0;
    end else begin
      hs_err_o   <= hs_err_d;
      rchk_err_o <= rchk_err_d;
    end
  end

endmodule
